// File: source/core_consts.svh
// Widths, depths, latencies and major opcodes shared by the core and its testbench.
// Include this header wherever one of the macros is needed.
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_XLEN        32
`define CORE_NREGS       32
`define CORE_REG_BITS    5
`define CORE_ROB_DEPTH   8
`define CORE_TAG_BITS    3
`define CORE_MUL_STAGES  3

// major opcodes, instr[6:0]
`define CORE_OPC_OP      7'b0110011
`define CORE_OPC_OP_IMM  7'b0010011
`define CORE_OPC_LUI     7'b0110111

`endif

// File: source/core_pkg.sv
// Types shared by decode, the execute lanes, the reorder buffer and the testbench.
// Modules pull them in with a wildcard import in their header.
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]     xlen_t;
  typedef logic [`CORE_REG_BITS-1:0] reg_idx_t;
  typedef logic [`CORE_TAG_BITS-1:0] rob_tag_t;

  // ALU_PASS_B forwards op_b, used by LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // issued to either lane, operands already resolved
  typedef struct packed {
    alu_op_t  alu_op;
    reg_idx_t rd;
    rob_tag_t tag;
    xlen_t    op_a;
    xlen_t    op_b;
  } uop_t;

  typedef struct packed {
    logic     done;
    reg_idx_t rd;
    xlen_t    data;
  } rob_entry_t;

endpackage

`default_nettype wire

// File: source/core_decode.sv
// Decode stage. Classifies the instruction, reads the register file, tracks
// pending destinations and issues one uop to the ALU or multiply lane.
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_decode import core_pkg::*; (
  input  wire           clk,
  input  wire           resetn,
  input  wire           instr_valid_i,
  input  wire xlen_t    instr_i,
  input  wire xlen_t    rs1_data_i,
  input  wire xlen_t    rs2_data_i,
  input  wire           rob_full_i,
  input  wire rob_tag_t alloc_tag_i,
  input  wire           retire_v_i,
  input  wire reg_idx_t retire_rd_i,
  output logic          instr_ready_o,
  output reg_idx_t      rs1_addr_o,
  output reg_idx_t      rs2_addr_o,
  output logic          alloc_v_o,
  output logic          alu_v_o,
  output logic          mul_v_o,
  output uop_t          uop_o,
  output logic          illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  logic       is_op, is_mul, is_opimm, is_lui, legal, needs_rob;
  logic       uses_rs1, uses_rs2, stall, accept, run_q;
  logic [`CORE_NREGS-1:0] pending_q, retire_clr, busy_regs, alloc_set;
  alu_op_t    alu_op;
  uop_t       uop_d;

  assign opcode     = instr_i[6:0];
  assign rd         = instr_i[11:7];
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  // only SUB and SRA may set funct7[5] in OP
  assign is_op    = (opcode == `CORE_OPC_OP) && ((funct7 == 7'h00) ||
                    ((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5))));
  assign is_mul   = (opcode == `CORE_OPC_OP) && (funct7 == 7'h01) && (funct3 == 3'd0);
  assign is_opimm = (opcode == `CORE_OPC_OP_IMM) &&
                    ((funct3 == 3'd1) ? (funct7 == 7'h00) :
                     (funct3 == 3'd5) ? ((funct7 == 7'h00) || (funct7 == 7'h20)) : 1'b1);
  assign is_lui   = (opcode == `CORE_OPC_LUI);

  assign legal     = is_op | is_mul | is_opimm | is_lui;
  assign needs_rob = legal && (rd != '0);
  assign uses_rs1  = is_op | is_mul | is_opimm;
  assign uses_rs2  = is_op | is_mul;

  // a register retiring now is already written in the register file
  always_comb begin
    retire_clr = '0;
    alloc_set  = '0;
    if (retire_v_i) begin
      retire_clr[retire_rd_i] = 1'b1;
    end
    if (alloc_v_o) begin
      alloc_set[rd] = 1'b1;
    end
  end

  assign busy_regs = pending_q & ~retire_clr;
  assign stall = (uses_rs1 & busy_regs[rs1_addr_o]) | (uses_rs2 & busy_regs[rs2_addr_o]) |
                 (needs_rob & (busy_regs[rd] | rob_full_i));

  assign instr_ready_o = run_q & ~stall;
  assign accept        = instr_valid_i & instr_ready_o;
  assign alloc_v_o     = accept & needs_rob;

  always_comb begin
    case (funct3)
      3'd0:    alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'd1:    alu_op = ALU_SLL;
      3'd2:    alu_op = ALU_SLT;
      3'd3:    alu_op = ALU_SLTU;
      3'd4:    alu_op = ALU_XOR;
      3'd5:    alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'd6:    alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
    if (is_lui) begin
      alu_op = ALU_PASS_B;
    end
  end

  // operand b is the register, the I immediate or the U immediate
  always_comb begin
    uop_d.alu_op = alu_op;
    uop_d.rd     = rd;
    uop_d.tag    = alloc_tag_i;
    uop_d.op_a   = is_lui ? '0 : rs1_data_i;
    if (is_lui) begin
      uop_d.op_b = {instr_i[31:12], 12'h000};
    end else if (is_opimm) begin
      uop_d.op_b = {{20{instr_i[31]}}, instr_i[31:20]};
    end else begin
      uop_d.op_b = rs2_data_i;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      run_q     <= 1'b0;
      pending_q <= '0;
      alu_v_o   <= 1'b0;
      mul_v_o   <= 1'b0;
      illegal_o <= 1'b0;
    end else begin
      run_q     <= 1'b1;
      pending_q <= busy_regs | alloc_set;
      alu_v_o   <= alloc_v_o & ~is_mul;
      mul_v_o   <= alloc_v_o & is_mul;
      illegal_o <= accept & ~legal;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      uop_o <= uop_d;
    end
  end

endmodule

`default_nettype wire

// File: source/core_alu.sv
// Single-cycle integer ALU lane. The result and its reorder tag are
// registered, so completion is reported one cycle after issue.
`timescale 1ns/1ps
`default_nettype none

module core_alu import core_pkg::*; (
  input  wire       clk,
  input  wire       resetn,
  input  wire       alu_v_i,
  input  wire uop_t uop_i,
  output logic      done_v_o,
  output rob_tag_t  done_tag_o,
  output xlen_t     done_data_o
);

  xlen_t      a, b, result;
  logic [4:0] shamt;

  assign a     = uop_i.op_a;
  assign b     = uop_i.op_b;
  assign shamt = b[4:0];

  always_comb begin
    case (uop_i.alu_op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = b;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      done_v_o <= 1'b0;
    end else begin
      done_v_o <= alu_v_i;
    end
  end

  always_ff @(posedge clk) begin
    done_tag_o  <= uop_i.tag;
    done_data_o <= result;
  end

endmodule

`default_nettype wire

// File: source/core_mul.sv
// Pipelined multiply lane returning the low word of op_a * op_b.
// A new multiply may enter every cycle; the result leaves after the pipeline depth.
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_mul import core_pkg::*; (
  input  wire       clk,
  input  wire       resetn,
  input  wire       mul_v_i,
  input  wire uop_t uop_i,
  output logic      done_v_o,
  output rob_tag_t  done_tag_o,
  output xlen_t     done_data_o
);

  localparam int STAGES = `CORE_MUL_STAGES;

  logic [STAGES-1:0] v_q;
  rob_tag_t          tag_q [STAGES];
  xlen_t             prod_q [STAGES-1];
  xlen_t             pp_lo, pp_lo_q;
  logic [15:0]       pp_hi, pp_hi_q;

  // low word only needs the low half of a times the high half of b
  assign pp_lo = uop_i.op_a * {16'h0000, uop_i.op_b[15:0]};
  assign pp_hi = uop_i.op_a[15:0] * uop_i.op_b[31:16];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[STAGES-2:0], mul_v_i};
    end
  end

  always_ff @(posedge clk) begin
    tag_q[0]  <= uop_i.tag;
    pp_lo_q   <= pp_lo;
    pp_hi_q   <= pp_hi;
    prod_q[0] <= pp_lo_q + {pp_hi_q, 16'h0000};
    for (int i = 1; i < STAGES; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
    for (int i = 1; i < STAGES - 1; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign done_v_o    = v_q[STAGES-1];
  assign done_tag_o  = tag_q[STAGES-1];
  assign done_data_o = prod_q[STAGES-2];

endmodule

`default_nettype wire

// File: source/core_rob.sv
// Reorder buffer with the architectural register file. Lanes complete entries
// by tag, the head retires in program order and writes the register file.
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_rob import core_pkg::*; (
  input  wire           clk,
  input  wire           resetn,
  input  wire           alloc_v_i,
  input  wire reg_idx_t alloc_rd_i,
  input  wire           alu_done_v_i,
  input  wire rob_tag_t alu_done_tag_i,
  input  wire xlen_t    alu_done_data_i,
  input  wire           mul_done_v_i,
  input  wire rob_tag_t mul_done_tag_i,
  input  wire xlen_t    mul_done_data_i,
  input  wire reg_idx_t rs1_addr_i,
  input  wire reg_idx_t rs2_addr_i,
  output rob_tag_t      alloc_tag_o,
  output logic          rob_full_o,
  output xlen_t         rs1_data_o,
  output xlen_t         rs2_data_o,
  output logic          retire_v_o,
  output reg_idx_t      retire_rd_o,
  output xlen_t         retire_data_o
);

  localparam int DEPTH = `CORE_ROB_DEPTH;

  rob_entry_t             rob_q [DEPTH];
  xlen_t                  regs_q [`CORE_NREGS];
  rob_tag_t               head_q, tail_q, rd_tag_q;
  logic [`CORE_TAG_BITS:0] count_q;
  logic                   rd_pend_q, retire;
  rob_entry_t             head;

  assign head        = rob_q[head_q];
  assign retire      = (count_q != '0) && head.done;
  assign alloc_tag_o = tail_q;
  assign rob_full_o  = (count_q == DEPTH);

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      rd_pend_q  <= 1'b0;
      rd_tag_q   <= '0;
      retire_v_o <= 1'b0;
    end else begin
      rd_pend_q  <= alloc_v_i;
      rd_tag_q   <= tail_q;
      retire_v_o <= retire;
      if (alloc_v_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc_v_i, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < DEPTH; i++) begin
        rob_q[i].done <= 1'b0;
      end
    end else begin
      if (alloc_v_i) begin
        rob_q[tail_q].done <= 1'b0;
      end
      // rd arrives with the issued uop, one cycle after allocation
      if (rd_pend_q) begin
        rob_q[rd_tag_q].rd <= alloc_rd_i;
      end
      if (alu_done_v_i) begin
        rob_q[alu_done_tag_i].done <= 1'b1;
        rob_q[alu_done_tag_i].data <= alu_done_data_i;
      end
      if (mul_done_v_i) begin
        rob_q[mul_done_tag_i].done <= 1'b1;
        rob_q[mul_done_tag_i].data <= mul_done_data_i;
      end
      if (retire) begin
        rob_q[head_q].done <= 1'b0;
      end
    end
  end

  // architectural state, written only at retire
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (retire) begin
      regs_q[head.rd] <= head.data;
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      retire_rd_o   <= head.rd;
      retire_data_o <= head.data;
    end
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
// Top level of the RV32 integer core. Connects decode, the ALU and multiply
// lanes and the reorder buffer; retirements leave in program order.
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
  input  wire        clk,
  input  wire        resetn,
  input  wire        instr_valid_i,
  input  wire xlen_t instr_i,
  output logic       instr_ready_o,
  output logic       retire_v_o,
  output reg_idx_t   retire_rd_o,
  output xlen_t      retire_data_o,
  output logic       illegal_o
);

  reg_idx_t rs1_addr, rs2_addr;
  xlen_t    rs1_data, rs2_data, alu_done_data, mul_done_data;
  rob_tag_t alloc_tag, alu_done_tag, mul_done_tag;
  logic     rob_full, alloc_v, alu_v, mul_v, alu_done_v, mul_done_v;
  uop_t     uop;

  core_decode u_decode (
    .clk           (clk),
    .resetn        (resetn),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rob_full_i    (rob_full),
    .alloc_tag_i   (alloc_tag),
    .retire_v_i    (retire_v_o),
    .retire_rd_i   (retire_rd_o),
    .instr_ready_o (instr_ready_o),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .alloc_v_o     (alloc_v),
    .alu_v_o       (alu_v),
    .mul_v_o       (mul_v),
    .uop_o         (uop),
    .illegal_o     (illegal_o)
  );

  core_alu u_alu (
    .clk         (clk),
    .resetn      (resetn),
    .alu_v_i     (alu_v),
    .uop_i       (uop),
    .done_v_o    (alu_done_v),
    .done_tag_o  (alu_done_tag),
    .done_data_o (alu_done_data)
  );

  core_mul u_mul (
    .clk         (clk),
    .resetn      (resetn),
    .mul_v_i     (mul_v),
    .uop_i       (uop),
    .done_v_o    (mul_done_v),
    .done_tag_o  (mul_done_tag),
    .done_data_o (mul_done_data)
  );

  core_rob u_rob (
    .clk             (clk),
    .resetn          (resetn),
    .alloc_v_i       (alloc_v),
    .alloc_rd_i      (uop.rd),
    .alu_done_v_i    (alu_done_v),
    .alu_done_tag_i  (alu_done_tag),
    .alu_done_data_i (alu_done_data),
    .mul_done_v_i    (mul_done_v),
    .mul_done_tag_i  (mul_done_tag),
    .mul_done_data_i (mul_done_data),
    .rs1_addr_i      (rs1_addr),
    .rs2_addr_i      (rs2_addr),
    .alloc_tag_o     (alloc_tag),
    .rob_full_o      (rob_full),
    .rs1_data_o      (rs1_data),
    .rs2_data_o      (rs2_data),
    .retire_v_o      (retire_v_o),
    .retire_rd_o     (retire_rd_o),
    .retire_data_o   (retire_data_o)
  );

endmodule

`default_nettype wire

// File: dv/core_sva.sv
// Reset and handshake assertions for the core.
// Bound to every core_top instance.
`timescale 1ns/1ps
`default_nettype none

module core_sva import core_pkg::*; (
  input wire           clk,
  input wire           resetn,
  input wire           instr_valid_i,
  input wire xlen_t    instr_i,
  input wire           instr_ready_o,
  input wire           retire_v_o,
  input wire reg_idx_t retire_rd_o,
  input wire           illegal_o
);

  // x0 never takes a reorder entry
  a_retire_rd_nonzero: assert property (@(posedge clk) disable iff (!resetn)
    retire_v_o |-> (retire_rd_o != '0))
    else $error("retirement reported for register zero");

  a_quiet_in_reset: assert property (@(posedge clk)
    !resetn |-> (!retire_v_o && !illegal_o))
    else $error("retire or illegal pulse while reset is asserted");

  // a stalled instruction must be held until it is taken
  a_instr_held: assert property (@(posedge clk) disable iff (!resetn)
    (instr_valid_i && !instr_ready_o) |=> (instr_valid_i && $stable(instr_i)))
    else $error("instruction dropped or changed while stalled");

endmodule

bind core_top core_sva u_sva (
  .clk           (clk),
  .resetn        (resetn),
  .instr_valid_i (instr_valid_i),
  .instr_i       (instr_i),
  .instr_ready_o (instr_ready_o),
  .retire_v_o    (retire_v_o),
  .retire_rd_o   (retire_rd_o),
  .illegal_o     (illegal_o)
);

`default_nettype wire

// File: dv/core_tb.sv
// Directed testbench for the core. Each test sends instructions, a register
// model applies the RV32 rules and queues the expected retirements, and a
// monitor compares them with the retire port in order.
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_tb import core_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int N_INSTR     = 31 + 60 + 56 + 11 + 6 + 8;
  localparam int WATCHDOG_NS = (16 + 20 * N_INSTR) * CLK_PERIOD;

  logic     clk, resetn, instr_valid_i;
  xlen_t    instr_i;
  logic     instr_ready_o, retire_v_o, illegal_o;
  reg_idx_t retire_rd_o;
  xlen_t    retire_data_o;

  xlen_t    model_regs [32];
  reg_idx_t exp_rd_q [$];
  xlen_t    exp_data_q [$];
  xlen_t    lcg_state = 32'd90;
  int       n_checks = 0;
  int       n_errors = 0;
  int       illegal_sent = 0;
  int       illegal_seen = 0;

  core_top u_dut (
    .clk           (clk),
    .resetn        (resetn),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .retire_v_o    (retire_v_o),
    .retire_rd_o   (retire_rd_o),
    .retire_data_o (retire_data_o),
    .illegal_o     (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xlen_t op_r(input logic [6:0] f7, input logic [2:0] f3,
                                 input reg_idx_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
  endfunction

  function automatic xlen_t op_i(input logic [11:0] imm, input logic [2:0] f3,
                                 input reg_idx_t rd, rs1);
    return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
  endfunction

  function automatic xlen_t op_lui(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, `CORE_OPC_LUI};
  endfunction

  // RV32IM result of one supported instruction on the model registers
  function automatic xlen_t model_exec(input xlen_t ins);
    xlen_t a, b, r;
    logic  is_op;
    is_op = (ins[6:0] == `CORE_OPC_OP);
    a = model_regs[ins[19:15]];
    b = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    case (ins[14:12])
      3'd0:    r = (is_op && ins[30]) ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5: begin
        if (ins[30]) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    if (is_op && ins[25]) begin
      r = a * b;
    end
    if (ins[6:0] == `CORE_OPC_LUI) begin
      r = {ins[31:12], 12'h000};
    end
    return r;
  endfunction

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns %s got x%0d expected x%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // hold the instruction until the core takes it
  // ready is sampled on the falling edge
  task automatic push_instr(input xlen_t ins);
    logic taken;
    taken = 1'b0;
    instr_valid_i = 1'b1;
    instr_i = ins;
    while (!taken) begin
      @(negedge clk);
      taken = instr_ready_o;
      @(posedge clk);
      #1;
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic send(input xlen_t ins);
    xlen_t value;
    value = model_exec(ins);
    if (ins[11:7] != 5'd0) begin
      model_regs[ins[11:7]] = value;
      exp_rd_q.push_back(ins[11:7]);
      exp_data_q.push_back(value);
    end
    push_instr(ins);
  endtask

  task automatic send_illegal(input xlen_t ins);
    illegal_sent++;
    push_instr(ins);
    @(negedge clk);
    check_flag("illegal_o", illegal_o, 1'b1);
    @(negedge clk);
    check_flag("illegal_o", illegal_o, 1'b0);
    @(posedge clk);
    #1;
  endtask

  // LUI plus ADDI with the upper part rounded for the sign of the low twelve bits
  task automatic load_reg(input reg_idx_t rd, input xlen_t value);
    xlen_t upper;
    upper = value + 32'h800;
    send(op_lui(upper[31:12], rd));
    send(op_i(value[11:0], 3'd0, rd, rd));
  endtask

  task automatic test_reset_idle();
    repeat (8) begin
      @(negedge clk);
      check_flag("retire_v_o", retire_v_o, 1'b0);
      check_flag("illegal_o", illegal_o, 1'b0);
    end
    @(posedge clk);
    #1;
    for (int r = 1; r < 32; r++) begin
      send(op_i(12'h000, 3'd0, 5'(r), 5'(r)));
    end
  endtask

  task automatic test_imm_ops();
    xlen_t       src [2];
    logic [11:0] imm [3];
    logic [4:0]  sh [3];
    int          n;
    src = '{32'h8000_1234, 32'h0765_4f0e};
    imm = '{12'hfff, 12'h7ff, 12'h800};
    sh  = '{5'd0, 5'd1, 5'd31};
    n   = 0;
    send(op_lui(20'hfffff, 5'd20));
    send(op_lui(20'h12345, 5'd21));
    for (int s = 0; s < 2; s++) begin
      load_reg(5'd1, src[s]);
      for (int f = 0; f < 8; f++) begin
        for (int k = 0; k < 3; k++) begin
          if (f == 1) begin
            send(op_i({7'h00, sh[k]}, 3'd1, 5'(10 + n % 8), 5'd1));
          end else if (f == 5) begin
            send(op_i({7'h00, sh[k]}, 3'd5, 5'(10 + n % 8), 5'd1));
            send(op_i({7'h20, sh[k]}, 3'd5, 5'(18 + n % 2), 5'd1));
          end else begin
            send(op_i(imm[k], 3'(f), 5'(10 + n % 8), 5'd1));
          end
          n++;
        end
      end
    end
  endtask

  task automatic test_reg_ops();
    for (int it = 0; it < 4; it++) begin
      load_reg(5'd1, lcg_next());
      load_reg(5'd2, lcg_next());
      for (int f = 0; f < 8; f++) begin
        send(op_r(7'h00, 3'(f), 5'(3 + f), 5'd1, 5'd2));
      end
      send(op_r(7'h20, 3'd0, 5'd11, 5'd1, 5'd2));
      send(op_r(7'h20, 3'd5, 5'd12, 5'd1, 5'd2));
    end
  endtask

  // the adds finish first inside the core but must retire after the MUL
  task automatic test_mul_order();
    load_reg(5'd4, lcg_next());
    load_reg(5'd5, lcg_next());
    send(op_r(7'h01, 3'd0, 5'd6, 5'd4, 5'd5));
    send(op_r(7'h00, 3'd0, 5'd7, 5'd4, 5'd5));
    send(op_r(7'h00, 3'd4, 5'd8, 5'd4, 5'd5));
    send(op_r(7'h00, 3'd6, 5'd9, 5'd4, 5'd5));
    send(op_r(7'h01, 3'd0, 5'd20, 5'd4, 5'd5));
    send(op_r(7'h01, 3'd0, 5'd21, 5'd5, 5'd5));
    send(op_r(7'h01, 3'd0, 5'd22, 5'd4, 5'd4));
  endtask

  task automatic test_dep_chain();
    send(op_r(7'h01, 3'd0, 5'd10, 5'd4, 5'd5));
    send(op_r(7'h00, 3'd0, 5'd11, 5'd10, 5'd4));
    send(op_r(7'h20, 3'd0, 5'd12, 5'd11, 5'd5));
    send(op_r(7'h01, 3'd0, 5'd13, 5'd12, 5'd12));
    send(op_r(7'h00, 3'd0, 5'd14, 5'd13, 5'd10));
    send(op_r(7'h20, 3'd0, 5'd15, 5'd14, 5'd13));
  endtask

  task automatic test_illegal_rd0();
    // SYSTEM, a load and MULH are outside the supported set
    send_illegal(32'h0000_0073);
    send_illegal(32'h0000_2083);
    send_illegal(op_r(7'h01, 3'd1, 5'd3, 5'd4, 5'd5));
    send(op_r(7'h00, 3'd0, 5'd0, 5'd4, 5'd5));
    send(op_i(12'h7ff, 3'd0, 5'd0, 5'd4));
    send(op_r(7'h01, 3'd0, 5'd0, 5'd4, 5'd5));
    send(op_i(12'h007, 3'd0, 5'd13, 5'd0));
    send(op_r(7'h00, 3'd0, 5'd14, 5'd4, 5'd0));
  endtask

  // retirements are checked in the order they were queued
  always @(negedge clk) begin
    if (resetn && retire_v_o) begin
      if (exp_rd_q.size() == 0) begin
        n_errors++;
        $display("unexpected retirement of x%0d at %0t ns", retire_rd_o, $time);
      end else begin
        check_reg("retire_rd_o", retire_rd_o, exp_rd_q.pop_front());
        check_data("retire_data_o", retire_data_o, exp_data_q.pop_front());
      end
    end
    if (resetn && illegal_o) begin
      illegal_seen++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t ns with %0d retirements outstanding",
             $time, exp_rd_q.size());
    $display("Checks failed");
    $finish;
  end

  initial begin
    resetn        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    // the core takes nothing while reset is held
    repeat (16) begin
      @(posedge clk);
      #1;
      check_flag("instr_ready_o", instr_ready_o, 1'b0);
    end
    resetn = 1'b1;
    test_reset_idle();
    test_imm_ops();
    test_reg_ops();
    test_mul_order();
    test_dep_chain();
    test_illegal_rd0();
    while (exp_rd_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (illegal_seen != illegal_sent) begin
      n_errors++;
      $display("saw %0d illegal pulses but sent %0d illegal instructions",
               illegal_seen, illegal_sent);
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/core_pkg.sv
source/core_decode.sv
source/core_alu.sv
source/core_mul.sv
source/core_rob.sv
source/core_top.sv
dv/core_sva.sv
dv/core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := core_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
